/* Makefile */
SIM      = verilator
TOP      = tb_pong_video
FILELIST = tb.f
FLAGS    = --binary --timing --assert
BUILD    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD)

/* bench/pong_patterns.txt */
# op and hex operands: M addr data | W addr data | R addr expected | E addr
# F frames | P x y rgb444, checked in the next full frame
# register access
W 04 0A
R 04 0A
W 0C 1234
R 0C 1234
W 00 2
R 00 2
W 14 FF
R 14 0
E 20
W 00 0
# camera words, three of them red
M 00 F800
M 08 F800
M 12 F800
M 0B 07E0
M 15 ABCD
M 2F 001F
# native mapping
P 0 0 F00
P 3 1 0F0
P 5 2 A76
P 7 5 00F
P 8 0 000
P 2 6 000
# upscaled
W 00 2
P 7 3 0F0
P A 4 A76
P F B 00F
# ball at 1,1
W 04 1
W 08 1
W 00 0
P 1 1 FFF
P 4 4 FFF
P 0 1 F00
P 5 2 A76
# scoring, three red pixels under the ball at 0,0
W 04 0
W 08 0
W 0C 3
W 00 1
F 1
R 14 3
R 10 1
F 2
R 10 3
W 0C 4
F 1
R 10 3
W 00 0
W 0C 0
F 1
R 10 3
W 10 0
R 10 0

/* bench/tb_pong_video.sv */
`timescale 1ns/1ns

module tb_pong_video;

    localparam int H_ACTIVE  = 16;
    localparam int H_FRONT   = 2;
    localparam int H_SYNC    = 2;
    localparam int H_BACK    = 2;
    localparam int V_ACTIVE  = 12;
    localparam int V_FRONT   = 1;
    localparam int V_SYNC    = 2;
    localparam int V_BACK    = 1;
    localparam int BALL_SIZE = 4;
    localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_LEN = H_TOTAL * V_TOTAL;
    localparam int BUF_DEPTH = (H_ACTIVE / 2) * (V_ACTIVE / 2);
    localparam int ADDR_W    = $clog2(BUF_DEPTH);

    logic                   clk;
    logic                   arst_n;
    game_pkg::apb_req_t     apb_req;
    game_pkg::apb_rsp_t     apb_rsp;
    logic                   cam_we;
    logic [ADDR_W-1:0]      cam_addr;
    vga_pkg::rgb565_t       cam_data;
    logic                   hsync;
    logic                   vsync;
    logic                   de;
    vga_pkg::rgb444_t       rgb;
    logic                   hit;
    logic [31:0]            rgb_word;

    // parsed pattern operations
    logic [7:0]  op_q [$];
    logic [31:0] arg_a [$];
    logic [31:0] arg_b [$];
    logic [31:0] arg_c [$];
    int          f_total = 0;
    int          p_total = 0;

    // pixels expected in the next captured frame
    int          exp_x [$];
    int          exp_y [$];
    logic [31:0] exp_rgb [$];

    // o_hit pulses since the last score clear
    int          hit_pulses = 0;
    logic        hit_prev   = 1'b0;

    int          fail_count  = 0;
    int unsigned cycles      = 0;
    int unsigned cycle_limit = 32'hFFFF_FFFF;

    assign rgb_word = {20'd0, rgb};

    pong_video_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .BALL_SIZE(BALL_SIZE)
    ) pong_video_top_i (
        .clk        (clk),
        .i_arst_n   (arst_n),
        .i_apb      (apb_req),
        .o_apb      (apb_rsp),
        .i_cam_we   (cam_we),
        .i_cam_addr (cam_addr),
        .i_cam_data (cam_data),
        .o_hsync    (hsync),
        .o_vsync    (vsync),
        .o_de       (de),
        .o_rgb      (rgb),
        .o_hit      (hit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // ----------------------------------------------------------------------
    // error reporting
    // ----------------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_count++;
        $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        $display("Result: FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_error(input string msg);
        fail_count++;
        $display("ERROR at t=%0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    initial begin
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles >= cycle_limit) begin
                $display("ERROR: timeout, the DUT did not finish within %0d cycles", cycles);
                $display("Result: FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    // one cycle per hit, counted on the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (hit) begin
                assert (!hit_prev) else report_error("o_hit stayed high for more than one cycle");
                hit_pulses++;
            end
            hit_prev = hit;
        end
    end

    // ----------------------------------------------------------------------
    // pattern file
    // ----------------------------------------------------------------------
    task automatic load_patterns();
        int          fd;
        int          ch;
        int          nargs;
        logic [7:0]  op;
        logic [31:0] args [3];
        fd = $fopen("bench/pong_patterns.txt", "r");
        if (fd == 0) begin
            report_error("cannot open bench/pong_patterns.txt");
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                ch = $fgetc(fd);
                while ((ch != 10) && (ch != -1)) begin
                    ch = $fgetc(fd);
                end
            end else begin
                case (op)
                    "M", "W", "R": nargs = 2;
                    "E", "F":      nargs = 1;
                    "P":           nargs = 3;
                    default: begin
                        nargs = 0;
                        report_error($sformatf("unknown operation '%c' in pattern file", op));
                    end
                endcase
                args[0] = '0;
                args[1] = '0;
                args[2] = '0;
                for (int k = 0; k < nargs; k++) begin
                    if ($fscanf(fd, " %h", args[k]) != 1) begin
                        report_error($sformatf("operand missing for '%c' in pattern file", op));
                    end
                end
                op_q.push_back(op);
                arg_a.push_back(args[0]);
                arg_b.push_back(args[1]);
                arg_c.push_back(args[2]);
                if (op == "F") begin
                    f_total += int'(args[0]);
                end
                if (op == "P") begin
                    p_total++;
                end
            end
        end
        $fclose(fd);
        if (op_q.size() == 0) begin
            report_error("pattern file holds no operations");
        end
    endtask

    function automatic void add_expected(input int idx);
        exp_x.push_back(int'(arg_a[idx]));
        exp_y.push_back(int'(arg_b[idx]));
        exp_rgb.push_back(arg_c[idx]);
    endfunction

    // ----------------------------------------------------------------------
    // bus and camera drivers
    // ----------------------------------------------------------------------
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic slverr);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        assert (apb_rsp.pready) else report_error("pready low in the access phase");
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic cam_write(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        cam_we   <= 1'b1;
        cam_addr <= addr[ADDR_W-1:0];
        cam_data <= data[15:0];
        @(posedge clk);
        cam_we   <= 1'b0;
    endtask

    task automatic fill_random();
        for (int k = 0; k < BUF_DEPTH; k++) begin
            // g forced high so never the target colour
            cam_write(32'(k), $urandom() | 32'h0000_0400);
        end
    endtask

    // ----------------------------------------------------------------------
    // frame capture
    // ----------------------------------------------------------------------
    task automatic wait_vsync_fall();
        logic prev;
        @(negedge clk);
        prev = vsync;
        @(negedge clk);
        while (!(prev && !vsync)) begin
            prev = vsync;
            @(negedge clk);
        end
    endtask

    task automatic capture_and_check();
        int   beats;
        int   hs_falls;
        int   found;
        int   px;
        int   py;
        logic hs_prev;
        logic vs_prev;
        logic frame_done;
        wait_vsync_fall();
        beats      = 0;
        hs_falls   = 0;
        found      = 0;
        hs_prev    = hsync;
        vs_prev    = vsync;
        frame_done = 1'b0;
        while (!frame_done) begin
            @(negedge clk);
            if (hs_prev && !hsync) begin
                hs_falls++;
            end
            if (de) begin
                px = beats % H_ACTIVE;
                py = beats / H_ACTIVE;
                for (int k = 0; k < exp_x.size(); k++) begin
                    if ((exp_x[k] == px) && (exp_y[k] == py)) begin
                        found++;
                        assert (rgb_word == exp_rgb[k]) else
                            report_mismatch($sformatf("o_rgb(%0d,%0d)", px, py),
                                            exp_rgb[k], rgb_word);
                    end
                end
                beats++;
            end
            frame_done = vs_prev && !vsync;
            hs_prev    = hsync;
            vs_prev    = vsync;
        end
        assert (hs_falls == V_TOTAL) else report_mismatch("o_hsync pulses", V_TOTAL, hs_falls);
        assert (beats == H_ACTIVE * V_ACTIVE) else
            report_mismatch("o_de beats", H_ACTIVE * V_ACTIVE, beats);
        assert (found == exp_x.size()) else report_error("an expected pixel never appeared");
    endtask

    task automatic run_patterns();
        int          idx;
        int          pulses_seen;
        logic [31:0] rd;
        logic        err;
        idx = 0;
        while (idx < op_q.size()) begin
            case (op_q[idx])
                "M": cam_write(arg_a[idx], arg_b[idx]);
                "W": begin
                    apb_access(1'b1, arg_a[idx][7:0], arg_b[idx], rd, err);
                    assert (!err) else report_mismatch("pslverr", 32'd0, {31'd0, err});
                    if (arg_a[idx][7:0] == game_pkg::REG_SCORE) begin
                        hit_pulses = 0;
                    end
                end
                "R": begin
                    apb_access(1'b0, arg_a[idx][7:0], 32'd0, rd, err);
                    assert (rd == arg_b[idx]) else
                        report_mismatch($sformatf("prdata@%02h", arg_a[idx][7:0]), arg_b[idx], rd);
                    // every score step comes with one o_hit pulse
                    if (arg_a[idx][7:0] == game_pkg::REG_SCORE) begin
                        pulses_seen = (hit_pulses > 255) ? 255 : hit_pulses;
                        assert (pulses_seen == int'(arg_b[idx])) else
                            report_mismatch("o_hit pulses", arg_b[idx], 32'(pulses_seen));
                    end
                end
                "E": begin
                    apb_access(1'b0, arg_a[idx][7:0], 32'd0, rd, err);
                    assert (err) else report_mismatch("pslverr", 32'd1, {31'd0, err});
                    assert (rd == 32'd0) else report_mismatch("prdata", 32'd0, rd);
                end
                "F": begin
                    repeat (int'(arg_a[idx])) wait_vsync_fall();
                end
                "P": begin
                    exp_x.delete();
                    exp_y.delete();
                    exp_rgb.delete();
                    add_expected(idx);
                    // neighbouring P lines share one frame
                    while ((idx + 1 < op_q.size()) && (op_q[idx + 1] == "P")) begin
                        idx++;
                        add_expected(idx);
                    end
                    capture_and_check();
                end
                default: report_error("bad operation in pattern queue");
            endcase
            idx++;
        end
    endtask

    initial begin
        void'($urandom(32'h7d29));
        arst_n   = 1'b0;
        apb_req  = '0;
        cam_we   = 1'b0;
        cam_addr = '0;
        cam_data = '0;
        load_patterns();
        // two frames per checked pixel and one per waited frame plus set-up slack
        cycle_limit = (f_total + 2 * p_total + 4) * FRAME_LEN
                      + 4 * op_q.size() + 2 * BUF_DEPTH + 100;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        fill_random();
        run_patterns();
        if (fail_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* hw/apb_regs.sv */
`timescale 1ns/1ns

module apb_regs (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  game_pkg::apb_req_t     i_apb,
    output game_pkg::apb_rsp_t     o_apb,
    output game_pkg::game_ctrl_t   o_ctrl,
    input  game_pkg::game_status_t i_status
);

    logic        access;
    logic        wr_en;
    logic        mapped;
    logic [31:0] rd_data;

    game_pkg::game_ctrl_t ctrl_q;

    assign access = i_apb.psel && i_apb.penable;
    assign wr_en  = access && i_apb.pwrite;

    // ----------------------------------------------------------------------
    // address decode and read mux
    // ----------------------------------------------------------------------
    always_comb begin
        mapped  = 1'b1;
        rd_data = '0;
        case (i_apb.paddr)
            game_pkg::REG_CTRL:   rd_data = {30'd0, ctrl_q.upscale, ctrl_q.enable};
            game_pkg::REG_BALL_X: rd_data = {22'd0, ctrl_q.ball_x};
            game_pkg::REG_BALL_Y: rd_data = {22'd0, ctrl_q.ball_y};
            game_pkg::REG_THRESH: rd_data = {16'd0, ctrl_q.threshold};
            game_pkg::REG_SCORE:  rd_data = {24'd0, i_status.score};
            game_pkg::REG_HITS:   rd_data = {16'd0, i_status.hits};
            default:              mapped  = 1'b0;
        endcase
    end

    assign o_apb.prdata  = rd_data;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = access && !mapped;

    // ----------------------------------------------------------------------
    // writable registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q.score_clear <= 1'b0;
            if (wr_en) begin
                case (i_apb.paddr)
                    game_pkg::REG_CTRL: begin
                        ctrl_q.enable  <= i_apb.pwdata[0];
                        ctrl_q.upscale <= i_apb.pwdata[1];
                    end
                    game_pkg::REG_BALL_X: ctrl_q.ball_x    <= i_apb.pwdata[9:0];
                    game_pkg::REG_BALL_Y: ctrl_q.ball_y    <= i_apb.pwdata[9:0];
                    game_pkg::REG_THRESH: ctrl_q.threshold <= i_apb.pwdata[15:0];
                    // any write clears the score
                    game_pkg::REG_SCORE:  ctrl_q.score_clear <= 1'b1;
                    default: ;
                endcase
            end
        end
    end

    assign o_ctrl = ctrl_q;

endmodule

/* hw/frame_buffer.sv */
`timescale 1ns/1ns

module frame_buffer #(
    parameter int DEPTH  = 76800,
    parameter int ADDR_W = 17
) (
    input  logic                  clk,
    input  logic                  i_we,
    input  logic [ADDR_W-1:0]     i_waddr,
    input  vga_pkg::rgb565_t      i_wdata,
    input  logic [ADDR_W-1:0]     i_raddr,
    output vga_pkg::rgb565_t      o_rdata
);

    vga_pkg::rgb565_t mem [DEPTH];

    // camera side
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // display side, one cycle read
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

/* hw/frame_reader.sv */
`timescale 1ns/1ns

module frame_reader #(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480,
    parameter int ADDR_W   = 17
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  vga_pkg::scan_beat_t   i_beat,
    input  logic                  i_upscale,
    output logic [ADDR_W-1:0]     o_raddr,
    input  vga_pkg::rgb565_t      i_rdata,
    output vga_pkg::scan_beat_t   o_beat,
    output vga_pkg::rgb565_t      o_pixel
);

    localparam int BUF_W = H_ACTIVE / 2;
    localparam int BUF_H = V_ACTIVE / 2;

    localparam vga_pkg::scan_beat_t BEAT_IDLE = '{
        x: 10'd0, y: 10'd0, de: 1'b0, hsync: 1'b1, vsync: 1'b1, frame_end: 1'b0
    };

    logic [9:0]          src_x;
    logic [9:0]          src_y;
    logic                mapped;
    vga_pkg::scan_beat_t beat_d1;
    logic                mapped_d1;
    logic                mapped_d2;

    // halve the position when scaling up
    assign src_x  = i_upscale ? {1'b0, i_beat.x[9:1]} : i_beat.x;
    assign src_y  = i_upscale ? {1'b0, i_beat.y[9:1]} : i_beat.y;
    assign mapped = i_beat.de && (src_x < 10'(BUF_W)) && (src_y < 10'(BUF_H));

    always_ff @(posedge clk) begin
        o_raddr <= ADDR_W'(src_y * BUF_W + src_x);
    end

    // two stages to line up with the RAM read
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            beat_d1   <= BEAT_IDLE;
            o_beat    <= BEAT_IDLE;
            mapped_d1 <= 1'b0;
            mapped_d2 <= 1'b0;
        end else begin
            beat_d1   <= i_beat;
            o_beat    <= beat_d1;
            mapped_d1 <= mapped;
            mapped_d2 <= mapped_d1;
        end
    end

    assign o_pixel = mapped_d2 ? i_rdata : '0;

endmodule

/* hw/game_pkg.sv */
package game_pkg;

    // ----------------------------------------------------------------------
    // APB bus
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // ----------------------------------------------------------------------
    // game control and status
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic        enable;
        logic        upscale;
        logic [9:0]  ball_x;
        logic [9:0]  ball_y;
        logic [15:0] threshold;
        logic        score_clear;
    } game_ctrl_t;

    typedef struct packed {
        logic [7:0]  score;
        logic [15:0] hits;
    } game_status_t;

    // register map
    parameter logic [7:0] REG_CTRL   = 8'h00;
    parameter logic [7:0] REG_BALL_X = 8'h04;
    parameter logic [7:0] REG_BALL_Y = 8'h08;
    parameter logic [7:0] REG_THRESH = 8'h0C;
    parameter logic [7:0] REG_SCORE  = 8'h10;
    parameter logic [7:0] REG_HITS   = 8'h14;

endpackage

/* hw/hit_detector.sv */
`timescale 1ns/1ns

module hit_detector #(
    parameter int BALL_SIZE = 16
) (
    input  logic                   clk,
    input  logic                   i_arst_n,
    input  vga_pkg::scan_beat_t    i_beat,
    input  vga_pkg::rgb565_t       i_pixel,
    input  game_pkg::game_ctrl_t   i_ctrl,
    output game_pkg::game_status_t o_status,
    output logic                   o_hit
);

    logic        take;
    logic        first_px;
    logic [15:0] hit_cnt;
    logic [15:0] cnt_base;
    logic [15:0] cnt_next;

    game_pkg::game_status_t status_q;

    // target pixel under the ball
    assign take = i_beat.de && vga_pkg::is_target(i_pixel)
                  && vga_pkg::in_square(i_beat.x, i_beat.y, i_ctrl.ball_x, i_ctrl.ball_y,
                                        BALL_SIZE);

    assign first_px = i_beat.de && (i_beat.x == '0) && (i_beat.y == '0);

    always_comb begin
        cnt_base = first_px ? 16'd0 : hit_cnt;
        cnt_next = cnt_base + {15'd0, take};
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            hit_cnt  <= '0;
            status_q <= '0;
            o_hit    <= 1'b0;
        end else begin
            o_hit <= 1'b0;
            if (i_beat.de) begin
                hit_cnt <= cnt_next;
            end
            // ------------------------------------------------------------
            // end of frame compare
            // ------------------------------------------------------------
            if (i_beat.frame_end) begin
                status_q.hits <= cnt_next;
                if (i_ctrl.enable && (cnt_next >= i_ctrl.threshold)) begin
                    o_hit <= 1'b1;
                    if (status_q.score != 8'hFF) begin
                        status_q.score <= status_q.score + 8'd1;
                    end
                end
            end
            // clear wins over a same-cycle hit
            if (i_ctrl.score_clear) begin
                status_q.score <= '0;
            end
        end
    end

    assign o_status = status_q;

endmodule

/* hw/pixel_mixer.sv */
`timescale 1ns/1ns

module pixel_mixer #(
    parameter int BALL_SIZE = 16
) (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  vga_pkg::scan_beat_t   i_beat,
    input  vga_pkg::rgb565_t      i_pixel,
    input  logic [9:0]            i_ball_x,
    input  logic [9:0]            i_ball_y,
    output logic                  o_hsync,
    output logic                  o_vsync,
    output logic                  o_de,
    output vga_pkg::rgb444_t      o_rgb
);

    logic             ball_px;
    vga_pkg::rgb444_t rgb_next;

    always_comb begin
        ball_px = vga_pkg::in_square(i_beat.x, i_beat.y, i_ball_x, i_ball_y, BALL_SIZE);
        if (!i_beat.de) begin
            rgb_next = '0;
        end else if (ball_px) begin
            rgb_next = vga_pkg::BALL_COLOR;
        end else begin
            // keep the top bits of each channel
            rgb_next = '{r: i_pixel.r[4:1], g: i_pixel.g[5:2], b: i_pixel.b[4:1]};
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_hsync <= 1'b1;
            o_vsync <= 1'b1;
            o_de    <= 1'b0;
            o_rgb   <= '0;
        end else begin
            o_hsync <= i_beat.hsync;
            o_vsync <= i_beat.vsync;
            o_de    <= i_beat.de;
            o_rgb   <= rgb_next;
        end
    end

endmodule

/* hw/pong_video_top.sv */
`timescale 1ns/1ns

module pong_video_top #(
    parameter int H_ACTIVE  = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_ACTIVE  = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int BALL_SIZE = 16,
    localparam int BUF_DEPTH = (H_ACTIVE / 2) * (V_ACTIVE / 2),
    localparam int ADDR_W    = $clog2(BUF_DEPTH)
) (
    input  logic                clk,
    input  logic                i_arst_n,
    input  game_pkg::apb_req_t  i_apb,
    output game_pkg::apb_rsp_t  o_apb,
    input  logic                i_cam_we,
    input  logic [ADDR_W-1:0]   i_cam_addr,
    input  vga_pkg::rgb565_t    i_cam_data,
    output logic                o_hsync,
    output logic                o_vsync,
    output logic                o_de,
    output vga_pkg::rgb444_t    o_rgb,
    output logic                o_hit
);

    vga_pkg::scan_beat_t    beat;
    vga_pkg::scan_beat_t    beat_d2;
    vga_pkg::rgb565_t       rd_data;
    vga_pkg::rgb565_t       pixel;
    logic [ADDR_W-1:0]      rd_addr;
    game_pkg::game_ctrl_t   ctrl;
    game_pkg::game_status_t status;

    // ----------------------------------------------------------------------
    // scan and buffer read
    // ----------------------------------------------------------------------
    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) vga_timing_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .o_beat   (beat)
    );

    frame_buffer #(.DEPTH(BUF_DEPTH), .ADDR_W(ADDR_W)) frame_buffer_i (
        .clk     (clk),
        .i_we    (i_cam_we),
        .i_waddr (i_cam_addr),
        .i_wdata (i_cam_data),
        .i_raddr (rd_addr),
        .o_rdata (rd_data)
    );

    frame_reader #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .ADDR_W(ADDR_W)) frame_reader_i (
        .clk       (clk),
        .i_arst_n  (i_arst_n),
        .i_beat    (beat),
        .i_upscale (ctrl.upscale),
        .o_raddr   (rd_addr),
        .i_rdata   (rd_data),
        .o_beat    (beat_d2),
        .o_pixel   (pixel)
    );

    // ----------------------------------------------------------------------
    // scoring, overlay and registers
    // ----------------------------------------------------------------------
    hit_detector #(.BALL_SIZE(BALL_SIZE)) hit_detector_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_beat   (beat_d2),
        .i_pixel  (pixel),
        .i_ctrl   (ctrl),
        .o_status (status),
        .o_hit    (o_hit)
    );

    pixel_mixer #(.BALL_SIZE(BALL_SIZE)) pixel_mixer_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_beat   (beat_d2),
        .i_pixel  (pixel),
        .i_ball_x (ctrl.ball_x),
        .i_ball_y (ctrl.ball_y),
        .o_hsync  (o_hsync),
        .o_vsync  (o_vsync),
        .o_de     (o_de),
        .o_rgb    (o_rgb)
    );

    apb_regs apb_regs_i (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_apb    (i_apb),
        .o_apb    (o_apb),
        .o_ctrl   (ctrl),
        .i_status (status)
    );

endmodule

/* hw/vga_pkg.sv */
package vga_pkg;

    // ----------------------------------------------------------------------
    // pixel formats
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [4:0] r;
        logic [5:0] g;
        logic [4:0] b;
    } rgb565_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb444_t;

    // one pixel slot of the scan, syncs active low
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       de;
        logic       hsync;
        logic       vsync;
        logic       frame_end;
    } scan_beat_t;

    // ----------------------------------------------------------------------
    // target colour and ball
    // ----------------------------------------------------------------------
    parameter logic [4:0] TARGET_R_MIN = 5'd24;
    parameter logic [5:0] TARGET_G_MAX = 6'd16;
    parameter logic [4:0] TARGET_B_MAX = 5'd8;

    parameter rgb444_t BALL_COLOR = 12'hFFF;

    function automatic logic is_target(input rgb565_t px);
        return (px.r >= TARGET_R_MIN) && (px.g < TARGET_G_MAX) && (px.b < TARGET_B_MAX);
    endfunction

    // square of side size, top-left corner at bx, by
    function automatic logic in_square(input logic [9:0] px, input logic [9:0] py,
                                       input logic [9:0] bx, input logic [9:0] by,
                                       input int size);
        logic [10:0] x_end;
        logic [10:0] y_end;
        x_end = {1'b0, bx} + 11'(size);
        y_end = {1'b0, by} + 11'(size);
        return (px >= bx) && ({1'b0, px} < x_end) && (py >= by) && ({1'b0, py} < y_end);
    endfunction

endpackage

/* hw/vga_timing.sv */
`timescale 1ns/1ns

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic                   clk,
    input  logic                   i_arst_n,
    output vga_pkg::scan_beat_t    o_beat
);

    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int VS_START = V_ACTIVE + V_FRONT;

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       line_end;

    assign line_end = (h_cnt == 10'(H_TOTAL - 1));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (line_end) begin
                h_cnt <= '0;
                if (v_cnt == 10'(V_TOTAL - 1)) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 10'd1;
                end
            end else begin
                h_cnt <= h_cnt + 10'd1;
            end
        end
    end

    // decode straight from the counters
    always_comb begin
        o_beat.x         = h_cnt;
        o_beat.y         = v_cnt;
        o_beat.de        = (h_cnt < 10'(H_ACTIVE)) && (v_cnt < 10'(V_ACTIVE));
        o_beat.hsync     = !((h_cnt >= 10'(HS_START)) && (h_cnt < 10'(HS_START + H_SYNC)));
        o_beat.vsync     = !((v_cnt >= 10'(VS_START)) && (v_cnt < 10'(VS_START + V_SYNC)));
        o_beat.frame_end = (h_cnt == 10'(H_ACTIVE - 1)) && (v_cnt == 10'(V_ACTIVE - 1));
    end

endmodule

/* tb.f */
hw/vga_pkg.sv
hw/game_pkg.sv
hw/vga_timing.sv
hw/frame_buffer.sv
hw/frame_reader.sv
hw/hit_detector.sv
hw/pixel_mixer.sv
hw/apb_regs.sv
hw/pong_video_top.sv
bench/tb_pong_video.sv
